/* src.f */
common/coherence_pkg.sv
bus_control/bus_control.sv
hdl/snoop_cache.sv
hdl/main_memory.sv
hdl/coherent_mem_top.sv
bench/coherent_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module coherent_mem_tb \
	-o coherent_mem_sim \
	&& ./obj_dir/coherent_mem_sim | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
grep -qx "TEST RESULT: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* bench/coherent_mem_tb.sv */
`timescale 1ns/100ps

module coherent_mem_tb import coherence_pkg::*; ();

	localparam int MEM_WORDS = 64;
	localparam int AW = $clog2(MEM_WORDS);
	// cycles allowed per access
	localparam int TIMEOUT = 200;

	logic CLK;
	logic nRST;
	core_req_t core0_req;
	core_req_t core1_req;
	core_req_t [1:0] core_req;
	core_rsp_t [1:0] core_rsp;

	// flat model of memory contents
	word_t ref_mem [MEM_WORDS];
	word_t rng;
	string test_name;

	// completed reads waiting for the compare process
	string name_q [$];
	word_t exp_q [$];
	word_t got_q [$];
	int checked;
	int check_errors;
	int timeout_errors;
	// cycles the last access of each core took
	int access_cycles [2];

	assign core_req[0] = core0_req;
	assign core_req[1] = core1_req;

	coherent_mem_top UUT (
		.CLK(CLK),
		.nRST(nRST),
		.core_req(core_req),
		.core_rsp(core_rsp)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic word_t xorshift(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// expected read value from the model
	function automatic word_t ref_word(input word_t addr);
		return ref_mem[addr[AW-1:0]];
	endfunction

	// writes update the model and reads queue up for comparing
	task automatic log_access(input int core, input logic wr, input word_t addr,
		input word_t wdata, input word_t rdata);
		if (wr) begin
			ref_mem[addr[AW-1:0]] = wdata;
		end else begin
			name_q.push_back($sformatf("%s core%0d addr %0d", test_name, core, addr));
			exp_q.push_back(ref_word(addr));
			got_q.push_back(rdata);
		end
	endtask

	// a hit answers in the cycle of its request
	task automatic check_hit_latency(input int core);
		if (access_cycles[core] != 1) begin
			$display("CHECK FAILED %s core%0d hit latency expected 1 actual %0d",
				test_name, core, access_cycles[core]);
			check_errors++;
		end
	endtask

	task automatic core0_access(input logic wr, input word_t addr, input word_t wdata);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		@(posedge CLK);
		core0_req <= '{ren: !wr, wen: wr, addr: addr, wdata: wdata};
		// busy looked at mid cycle
		while (!done && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
			if (!core_rsp[0].busy) begin
				done = 1'b1;
			end
		end
		access_cycles[0] = cycles;
		if (done) begin
			log_access(0, wr, addr, wdata, core_rsp[0].rdata);
		end else begin
			$display("core 0 got no response for address %0d within %0d cycles", addr, TIMEOUT);
			timeout_errors++;
		end
		@(posedge CLK);
		core0_req <= '0;
	endtask

	task automatic core1_access(input logic wr, input word_t addr, input word_t wdata);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		@(posedge CLK);
		core1_req <= '{ren: !wr, wen: wr, addr: addr, wdata: wdata};
		while (!done && cycles < TIMEOUT) begin
			@(negedge CLK);
			cycles++;
			if (!core_rsp[1].busy) begin
				done = 1'b1;
			end
		end
		access_cycles[1] = cycles;
		if (done) begin
			log_access(1, wr, addr, wdata, core_rsp[1].rdata);
		end else begin
			$display("core 1 got no response for address %0d within %0d cycles", addr, TIMEOUT);
			timeout_errors++;
		end
		@(posedge CLK);
		core1_req <= '0;
	endtask

	// reads queued at negedge get checked on the next posedge
	initial begin
		check_errors = 0;
		checked = 0;
		forever begin
			@(posedge CLK);
			while (checked < got_q.size()) begin
				if (got_q[checked] !== exp_q[checked]) begin
					$display("CHECK FAILED %s expected %h actual %h",
						name_q[checked], exp_q[checked], got_q[checked]);
					check_errors++;
				end
				checked++;
			end
		end
	end

	initial begin
		word_t a0, a1, d0, d1;
		logic w0, w1, pick1;
		int drain;
		nRST = 1'b0;
		core0_req = '0;
		core1_req = '0;
		rng = 32'hdb01_6652;
		timeout_errors = 0;
		test_name = "reset";
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		repeat (2) @(posedge CLK);
		nRST <= 1'b1;

		// untouched memory reads back zero
		test_name = "cold_read";
		core0_access(1'b0, 32'd5, '0);
		core1_access(1'b0, 32'd9, '0);

		// write miss then hit in modified
		test_name = "write_hit";
		core0_access(1'b1, 32'd10, 32'hcafe_0010);
		core0_access(1'b0, 32'd10, '0);
		check_hit_latency(0);

		// dirty line flushed on core 1 snoop and kept shared by core 0
		test_name = "snoop_wb";
		core0_access(1'b1, 32'd13, 32'h1234_abcd);
		core1_access(1'b0, 32'd13, '0);
		core0_access(1'b0, 32'd13, '0);
		check_hit_latency(0);

		// shared on both before core 1 upgrades
		test_name = "upgrade_inv";
		core0_access(1'b0, 32'd20, '0);
		core1_access(1'b0, 32'd20, '0);
		core1_access(1'b1, 32'd20, 32'h5a5a_0020);
		core0_access(1'b0, 32'd20, '0);

		// addresses 1 5 9 13 all land in set 1
		test_name = "victim_wb";
		for (int i = 0; i < 4; i++) begin
			core0_access(1'b1, word_t'(1 + 4 * i), 32'hbeef_0000 + i);
		end
		for (int i = 0; i < 4; i++) begin
			core0_access(1'b0, word_t'(1 + 4 * i), '0);
		end
		core1_access(1'b0, 32'd5, '0);

		// both cores at once on the low and high halves
		test_name = "random_parallel";
		for (int i = 0; i < 100; i++) begin
			rng = xorshift(rng);
			w0 = rng[31];
			a0 = {27'd0, rng[4:0]};
			rng = xorshift(rng);
			d0 = rng;
			rng = xorshift(rng);
			w1 = rng[31];
			a1 = {26'd0, 1'b1, rng[4:0]};
			rng = xorshift(rng);
			d1 = rng;
			fork
				core0_access(w0, a0, d0);
				core1_access(w1, a1, d1);
			join
		end

		// one access at a time from either core over all of memory
		test_name = "random_shared";
		for (int i = 0; i < 100; i++) begin
			rng = xorshift(rng);
			w0 = rng[31];
			pick1 = rng[30];
			a0 = {26'd0, rng[5:0]};
			rng = xorshift(rng);
			d0 = rng;
			if (pick1) begin
				core1_access(w0, a0, d0);
			end else begin
				core0_access(w0, a0, d0);
			end
		end

		// give the compare process time to drain
		drain = 0;
		@(negedge CLK);
		while (checked < got_q.size() && drain < 10) begin
			@(negedge CLK);
			drain++;
		end
		if (checked < got_q.size()) begin
			$display("compare process left %0d reads unchecked", got_q.size() - checked);
			timeout_errors++;
		end

		$display("summary: %0d reads checked, %0d check errors, %0d timeout errors",
			checked, check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* hdl/coherent_mem_top.sv */
`timescale 1ns/100ps

module coherent_mem_top import coherence_pkg::*; #(
	parameter int SETS = 4,
	parameter int MEM_WORDS = 64,
	parameter int MEM_WAIT = 2
) (
	input logic CLK,
	input logic nRST,
	input core_req_t [1:0] core_req,
	output core_rsp_t [1:0] core_rsp
);

	bus_req_t [1:0] cache_req;
	bus_rsp_t [1:0] cache_rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	// one data cache per core
	for (genvar i = 0; i < 2; i++) begin : g_cache
		snoop_cache #(
			.SETS(SETS)
		) u_cache (
			.CLK(CLK),
			.nRST(nRST),
			.core_req(core_req[i]),
			.core_rsp(core_rsp[i]),
			.bus_req(cache_req[i]),
			.bus_rsp(cache_rsp[i])
		);
	end

	// shared snooping bus
	bus_control u_bus (
		.CLK(CLK),
		.nRST(nRST),
		.cache_req(cache_req),
		.cache_rsp(cache_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	main_memory #(
		.MEM_WORDS(MEM_WORDS),
		.MEM_WAIT(MEM_WAIT)
	) u_mem (
		.CLK(CLK),
		.nRST(nRST),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

endmodule

/* hdl/main_memory.sv */
`timescale 1ns/100ps

module main_memory import coherence_pkg::*; #(
	parameter int MEM_WORDS = 64,
	parameter int MEM_WAIT = 2
) (
	input logic CLK,
	input logic nRST,
	input mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	localparam int AW = $clog2(MEM_WORDS);
	// counter wide enough for MEM_WAIT, one bit at least
	localparam int CW = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

	word_t mem [MEM_WORDS];
	logic [CW-1:0] wait_cnt;
	logic [AW-1:0] word_idx;
	logic active, ready;

	assign active = mem_req.ren | mem_req.wen;
	// ready after MEM_WAIT stalled cycles
	assign ready = active && (wait_cnt == CW'(MEM_WAIT));
	assign word_idx = mem_req.addr[AW-1:0];

	assign mem_rsp.dwait = !ready;
	assign mem_rsp.dload = mem[word_idx];

	// restart after each ack or when idle
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wait_cnt <= '0;
		end else if (!active || ready) begin
			wait_cnt <= '0;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// array starts out cleared, writes land on the ack cycle
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (ready && mem_req.wen) begin
			mem[word_idx] <= mem_req.store;
		end
	end

endmodule

/* hdl/snoop_cache.sv */
`timescale 1ns/100ps

module snoop_cache import coherence_pkg::*; #(
	parameter int SETS = 4
) (
	input logic CLK,
	input logic nRST,
	input core_req_t core_req,
	output core_rsp_t core_rsp,
	output bus_req_t bus_req,
	input bus_rsp_t bus_rsp
);

	localparam int IW = $clog2(SETS);
	localparam int TW = 32 - IW;

	// what the pending core access needs next
	typedef enum logic [1:0] {
		ACT_HIT,
		ACT_WB,
		ACT_FILL,
		ACT_UPG
	} act_t;

	logic [TW-1:0] tags [SETS];
	word_t data [SETS];
	msi_t line_st [SETS];

	logic [IW-1:0] idx, sidx;
	logic [TW-1:0] tag, stag;
	logic active, tag_hit, bus_done, complete;
	logic snoop_hit, snoop_ack;
	act_t act;

	// core side lookup
	assign idx = core_req.addr[IW-1:0];
	assign tag = core_req.addr[31:IW];
	assign active = core_req.ren | core_req.wen;
	assign tag_hit = (tags[idx] == tag) && (line_st[idx] != MSI_I);

	// snoop side lookup, separate index
	assign sidx = bus_rsp.ccsnoopaddr[IW-1:0];
	assign stag = bus_rsp.ccsnoopaddr[31:IW];
	assign snoop_hit = bus_rsp.ccwait && (tags[sidx] == stag) && (line_st[sidx] != MSI_I);
	// dirty line flushed by the bus
	assign snoop_ack = bus_req.cctrans && !bus_rsp.dwait;

	// own request acked only outside a snoop window
	assign bus_done = !bus_rsp.dwait && !bus_rsp.ccwait;

	always_comb begin
		if (tag_hit && (line_st[idx] == MSI_M || !core_req.wen)) begin
			act = ACT_HIT;
		end else if (tag_hit) begin
			// write to a shared line
			act = ACT_UPG;
		end else if (line_st[idx] == MSI_M) begin
			act = ACT_WB;
		end else begin
			act = ACT_FILL;
		end
	end

	// hits wait out a snoop so flushed data stays current
	assign complete = active && ((act == ACT_HIT && !bus_rsp.ccwait) ||
		(bus_done && (act == ACT_FILL || act == ACT_UPG)));

	assign core_rsp.busy = active && !complete;
	assign core_rsp.rdata = (act == ACT_FILL) ? bus_rsp.dload : data[idx];

	assign bus_req.dren = active && (act == ACT_FILL);
	assign bus_req.dwen = active && (act == ACT_WB);
	assign bus_req.ccwrite = active && core_req.wen && (act == ACT_FILL || act == ACT_UPG);
	assign bus_req.cctrans = snoop_hit && (line_st[sidx] == MSI_M);
	// snoop answer borrows the address and data lines
	assign bus_req.daddr = bus_req.cctrans ? bus_rsp.ccsnoopaddr :
		(act == ACT_WB) ? {tags[idx], idx} : core_req.addr;
	assign bus_req.dstore = bus_req.cctrans ? data[sidx] : data[idx];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < SETS; i++) begin
				line_st[i] <= MSI_I;
			end
		end else begin
			// snoop and own updates never share a cycle
			if (snoop_hit && bus_rsp.ccinv) begin
				line_st[sidx] <= MSI_I;
			end else if (snoop_ack) begin
				line_st[sidx] <= MSI_S;
			end
			if (active && bus_done) begin
				case (act)
					ACT_WB: line_st[idx] <= MSI_I;
					ACT_FILL: line_st[idx] <= core_req.wen ? MSI_M : MSI_S;
					ACT_UPG: line_st[idx] <= MSI_M;
					default: line_st[idx] <= line_st[idx];
				endcase
			end
		end
	end

	// tag and data arrays
	always_ff @(posedge CLK) begin
		if (complete && act == ACT_FILL) begin
			tags[idx] <= tag;
			data[idx] <= core_req.wen ? core_req.wdata : bus_rsp.dload;
		end else if (complete && core_req.wen) begin
			data[idx] <= core_req.wdata;
		end
	end

endmodule

/* bus_control/bus_control.sv */
`timescale 1ns/100ps

module bus_control import coherence_pkg::*; (
	input logic CLK,
	input logic nRST,
	input bus_req_t [1:0] cache_req,
	output bus_rsp_t [1:0] cache_rsp,
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp
);

	typedef enum logic [2:0] {
		IDLE,
		ARBITRATE,
		SNOOP,
		MEM_WB,
		MOD_WB,
		MEM_READ,
		COMPLETE
	} bus_state_t;

	bus_state_t state, next_state;
	logic grant, next_grant;
	logic other;
	logic [1:0] live;
	mem_req_t next_mem_req;
	word_t read_data;

	// any of the three requests counts as live
	assign live[0] = cache_req[0].dren | cache_req[0].dwen | cache_req[0].ccwrite;
	assign live[1] = cache_req[1].dren | cache_req[1].dwen | cache_req[1].ccwrite;

	// the cache that lost arbitration is the one snooped
	assign other = ~grant;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			grant <= 1'b0;
			mem_req <= '0;
		end else begin
			state <= next_state;
			grant <= next_grant;
			mem_req <= next_mem_req;
		end
	end

	// read word kept for the complete state
	always_ff @(posedge CLK) begin
		if (state == MEM_READ && !mem_rsp.dwait) begin
			read_data <= mem_rsp.dload;
		end
	end

	always_comb begin
		next_state = state;
		next_grant = grant;
		// memory request held unless a state changes it
		next_mem_req = mem_req;

		for (int i = 0; i < 2; i++) begin
			cache_rsp[i].dwait = 1'b1;
			cache_rsp[i].dload = '0;
			cache_rsp[i].ccwait = 1'b0;
			cache_rsp[i].ccinv = 1'b0;
			// snoop address broadcast to both
			cache_rsp[i].ccsnoopaddr = cache_req[grant].daddr;
		end

		// snoop window lasts while the winner is still asking
		if (state != IDLE && state != ARBITRATE) begin
			cache_rsp[other].ccwait = live[grant];
		end

		case (state)
			IDLE: begin
				if (live[0] || live[1]) begin
					next_state = ARBITRATE;
				end
			end

			ARBITRATE: begin
				// cache 0 always wins a tie
				next_grant = ~live[0];
				next_state = SNOOP;
			end

			SNOOP: begin
				if (cache_req[grant].dwen) begin
					// victim writeback, straight to memory
					next_state = MEM_WB;
					next_mem_req = '{ren: 1'b0, wen: 1'b1,
						addr: cache_req[grant].daddr, store: cache_req[grant].dstore};
				end else if (live[grant] && cache_req[other].cctrans) begin
					// other side is dirty, flush it first
					next_state = MOD_WB;
					next_mem_req = '{ren: 1'b0, wen: 1'b1,
						addr: cache_req[other].daddr, store: cache_req[other].dstore};
				end else if (cache_req[grant].dren) begin
					// read for ownership kills the other copy now
					cache_rsp[other].ccinv = cache_req[grant].ccwrite;
					next_state = MEM_READ;
					next_mem_req = '{ren: 1'b1, wen: 1'b0,
						addr: cache_req[grant].daddr, store: '0};
				end else if (cache_req[grant].ccwrite) begin
					// upgrade, no memory traffic
					cache_rsp[other].ccinv = 1'b1;
					cache_rsp[grant].dwait = 1'b0;
					next_state = IDLE;
				end else begin
					next_state = IDLE;
				end
			end

			MEM_WB: begin
				if (!mem_rsp.dwait) begin
					cache_rsp[grant].dwait = 1'b0;
					next_mem_req = '0;
					next_state = IDLE;
				end
			end

			MOD_WB: begin
				if (!mem_rsp.dwait) begin
					// snooped cache sees its flush acknowledged
					cache_rsp[other].dwait = 1'b0;
					cache_rsp[other].ccinv = cache_req[grant].ccwrite;
					if (cache_req[grant].dren) begin
						next_state = MEM_READ;
						next_mem_req = '{ren: 1'b1, wen: 1'b0,
							addr: cache_req[grant].daddr, store: '0};
					end else begin
						// upgrade done once the dirty copy is out
						cache_rsp[grant].dwait = 1'b0;
						next_mem_req = '0;
						next_state = IDLE;
					end
				end
			end

			MEM_READ: begin
				if (!mem_rsp.dwait) begin
					next_mem_req = '0;
					next_state = COMPLETE;
				end
			end

			COMPLETE: begin
				cache_rsp[grant].dwait = 1'b0;
				cache_rsp[grant].dload = read_data;
				next_state = IDLE;
			end

			default: begin
				next_mem_req = '0;
				next_state = IDLE;
			end
		endcase
	end

endmodule

/* common/coherence_pkg.sv */
package coherence_pkg;

	// data and address word
	typedef logic [31:0] word_t;

	// cache line state
	typedef enum logic [1:0] {
		MSI_I = 2'b00,
		MSI_S = 2'b01,
		MSI_M = 2'b10
	} msi_t;

	// core side access, held until busy drops
	typedef struct packed {
		logic ren;
		logic wen;
		word_t addr;
		word_t wdata;
	} core_req_t;

	typedef struct packed {
		logic busy;
		word_t rdata;
	} core_rsp_t;

	// cache to bus controller
	typedef struct packed {
		logic dren;
		logic dwen;
		logic ccwrite;
		// snoop answer, line held modified
		logic cctrans;
		word_t daddr;
		word_t dstore;
	} bus_req_t;

	// bus controller to cache
	typedef struct packed {
		logic dwait;
		word_t dload;
		logic ccwait;
		logic ccinv;
		word_t ccsnoopaddr;
	} bus_rsp_t;

	// bus controller to memory
	typedef struct packed {
		logic ren;
		logic wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	typedef struct packed {
		logic dwait;
		word_t dload;
	} mem_rsp_t;

endpackage
